// File: hw/back_end_consts.svh
`ifndef BACK_END_CONSTS_SVH
`define BACK_END_CONSTS_SVH

// Datapath and register number widths
`define XLEN       32
`define REG_ADDR_W 5

// Reorder buffer geometry, the tag width covers every slot exactly
`define ROB_DEPTH  8
`define ROB_TAG_W  3

// Multiplier iterations, one byte of the second operand per step
`define MUL_STEPS  4

// Operation codes
`define OP_W       4
`define OP_ADD     4'h0
`define OP_SUB     4'h1
`define OP_AND     4'h2
`define OP_OR      4'h3
`define OP_XOR     4'h4
`define OP_SLL     4'h5
`define OP_SRL     4'h6
`define OP_SLT     4'h7
`define OP_MUL     4'h8

`endif

// File: hw/back_end_pkg.sv
`include "back_end_consts.svh"

package back_end_pkg;

    // Operand or result word
    typedef logic [`XLEN-1:0] data_word_t;

    // Architectural register number
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Reorder buffer slot, also used as the age label of an instruction
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // Operation code carried from issue to the units
    typedef logic [`OP_W-1:0] op_t;

    // Iterative multiplier control
    typedef enum logic [0:0] {
        MUL_IDLE = 1'b0,
        MUL_BUSY = 1'b1
    } mul_state_t;

endpackage : back_end_pkg

// File: hw/bypass_network.sv
`timescale 1ns/100ps

`include "back_end_consts.svh"

module bypass_network import back_end_pkg::*; (
    input  reg_addr_t  src_a_i,
    input  reg_addr_t  src_b_i,
    input  logic       imm_i,
    input  data_word_t rf_a_i,
    input  data_word_t rf_b_i,
    input  logic       exe_valid_i,
    input  reg_addr_t  exe_dest_i,
    input  data_word_t exe_result_i,
    input  logic       rob_hit_a_i,
    input  logic       rob_hit_b_i,
    input  data_word_t rob_data_a_i,
    input  data_word_t rob_data_b_i,
    output data_word_t operand_a_o,
    output data_word_t operand_b_o
);

    // The instruction in the issue register is the youngest producer
    // Completed reorder buffer entries come next, the register file last
    function automatic data_word_t pick_operand(input reg_addr_t  src,
                                                input data_word_t rf_val,
                                                input logic       rob_hit,
                                                input data_word_t rob_val);
        if (exe_valid_i && (exe_dest_i == src)) begin
            return exe_result_i;
        end else if (rob_hit) begin
            return rob_val;
        end
        return rf_val;
    endfunction

    always_comb begin
        operand_a_o = pick_operand(src_a_i, rf_a_i, rob_hit_a_i, rob_data_a_i);

        // An immediate arrives on the register file lane and is never forwarded
        if (imm_i) begin
            operand_b_o = rf_b_i;
        end else begin
            operand_b_o = pick_operand(src_b_i, rf_b_i, rob_hit_b_i, rob_data_b_i);
        end
    end

endmodule : bypass_network

// File: hw/issue_stage.sv
`timescale 1ns/100ps

`include "back_end_consts.svh"

module issue_stage import back_end_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       issue_valid_i,
    input  op_t        issue_op_i,
    input  reg_addr_t  issue_src_a_i,
    input  reg_addr_t  issue_src_b_i,
    input  reg_addr_t  issue_dest_i,
    input  logic       issue_imm_i,
    input  logic       issue_illegal_i,
    input  data_word_t issue_pc_i,
    input  data_word_t operand_a_i,
    input  data_word_t operand_b_i,
    input  logic       rob_full_i,
    input  logic       flush_i,
    input  logic       mul_busy_i,
    input  reg_addr_t  mul_dest_i,
    output logic       issue_ready_o,
    output logic       accept_o,
    output logic       ex_valid_o,
    output op_t        ex_op_o,
    output reg_addr_t  ex_dest_o,
    output rob_tag_t   ex_tag_o,
    output logic       ex_illegal_o,
    output data_word_t ex_pc_o,
    output data_word_t ex_a_o,
    output data_word_t ex_b_o,
    input  rob_tag_t   alloc_tag_i
);

    logic mul_in_ex;
    logic new_is_mul;
    logic mul_hazard;

    // True when the incoming instruction reads the given register
    // The second source does not count when it is an immediate
    function automatic logic reads_reg(input reg_addr_t dest);
        return (issue_src_a_i == dest) || (!issue_imm_i && (issue_src_b_i == dest));
    endfunction

    // ======================================================================
    // Multiplier hazard and ready level
    // ======================================================================

    // An illegal multiply never reaches the multiplier
    assign mul_in_ex  = ex_valid_o && (ex_op_o == `OP_MUL) && !ex_illegal_o;
    assign new_is_mul = (issue_op_i == `OP_MUL);

    // Only one multiply may be in flight, and nothing may read its result early
    assign mul_hazard = (mul_in_ex && (new_is_mul || reads_reg(ex_dest_o)))
                     || (mul_busy_i && (new_is_mul || reads_reg(mul_dest_i)));

    assign issue_ready_o = !rob_full_i && !flush_i && !mul_hazard;
    assign accept_o      = issue_valid_i && issue_ready_o;

    // ======================================================================
    // Issue register
    // ======================================================================

    // The register always drains in one cycle so it never has to stall
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= accept_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_o) begin
            ex_op_o      <= issue_op_i;
            ex_dest_o    <= issue_dest_i;
            ex_tag_o     <= alloc_tag_i;
            ex_illegal_o <= issue_illegal_i;
            ex_pc_o      <= issue_pc_i;
            ex_a_o       <= operand_a_i;
            ex_b_o       <= operand_b_i;
        end
    end

endmodule : issue_stage

// File: hw/alu_unit.sv
`timescale 1ns/100ps

`include "back_end_consts.svh"

module alu_unit import back_end_pkg::*; (
    input  op_t        op_i,
    input  data_word_t a_i,
    input  data_word_t b_i,
    output data_word_t result_o
);

    // Shift amount comes from the low bits of the second operand
    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            `OP_ADD: result_o = a_i + b_i;
            `OP_SUB: result_o = a_i - b_i;
            `OP_AND: result_o = a_i & b_i;
            `OP_OR:  result_o = a_i | b_i;
            `OP_XOR: result_o = a_i ^ b_i;
            `OP_SLL: result_o = a_i << shamt;
            `OP_SRL: result_o = a_i >> shamt;

            // Signed compare gives a single bit result
            `OP_SLT: begin
                result_o = data_word_t'($signed(a_i) < $signed(b_i));
            end

            // Multiplies are handled by the multiplier and never written from here
            default: result_o = '0;
        endcase
    end

endmodule : alu_unit

// File: hw/mul_unit.sv
`timescale 1ns/100ps

`include "back_end_consts.svh"

module mul_unit import back_end_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,
    input  logic       start_i,
    input  data_word_t a_i,
    input  data_word_t b_i,
    input  reg_addr_t  dest_i,
    input  rob_tag_t   tag_i,
    output logic       busy_o,
    output reg_addr_t  dest_o,
    output logic       done_o,
    output rob_tag_t   tag_o,
    output data_word_t result_o
);

    localparam int STEP_W = $clog2(`MUL_STEPS);

    mul_state_t  state_q;
    logic [STEP_W-1:0] step_q;
    data_word_t  a_q;
    data_word_t  b_q;
    data_word_t  acc_q;
    data_word_t  partial;
    reg_addr_t   dest_i_q;
    rob_tag_t    tag_i_q;

    // a_q is pre-shifted so each partial product lands in place
    assign partial = a_q * data_word_t'(b_q[7:0]);

    assign busy_o   = (state_q == MUL_BUSY);
    assign done_o   = busy_o && (step_q == STEP_W'(`MUL_STEPS - 1));
    assign result_o = acc_q + partial;
    assign dest_o   = dest_i_q;
    assign tag_o    = tag_i_q;

    // ======================================================================
    // Control FSM
    // ======================================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q <= MUL_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (start_i) begin
                        state_q <= MUL_BUSY;
                        step_q  <= '0;
                    end
                end
                MUL_BUSY: begin
                    step_q <= step_q + 1'b1;
                    // Last byte consumed, the result leaves this cycle
                    if (done_o) begin
                        state_q <= MUL_IDLE;
                    end
                end
                default: state_q <= MUL_IDLE;
            endcase
        end
    end

    // Operands shift one byte per step while the low product accumulates
    always_ff @(posedge clk_i) begin
        if (start_i && !busy_o) begin
            a_q      <= a_i;
            b_q      <= b_i;
            acc_q    <= '0;
            dest_i_q <= dest_i;
            tag_i_q  <= tag_i;
        end else if (busy_o) begin
            a_q   <= a_q << 8;
            b_q   <= b_q >> 8;
            acc_q <= acc_q + partial;
        end
    end

endmodule : mul_unit

// File: hw/reorder_buffer.sv
`timescale 1ns/100ps

`include "back_end_consts.svh"

module reorder_buffer import back_end_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       alloc_i,
    input  reg_addr_t  alloc_dest_i,
    input  data_word_t alloc_pc_i,
    input  logic       exe_write_i,
    input  rob_tag_t   exe_tag_i,
    input  data_word_t exe_result_i,
    input  logic       exe_exception_i,
    input  logic       mul_write_i,
    input  rob_tag_t   mul_tag_i,
    input  data_word_t mul_result_i,
    input  reg_addr_t  fwd_src_a_i,
    input  reg_addr_t  fwd_src_b_i,
    output rob_tag_t   alloc_tag_o,
    output logic       full_o,
    output logic       empty_o,
    output logic       fwd_hit_a_o,
    output data_word_t fwd_data_a_o,
    output logic       fwd_hit_b_o,
    output data_word_t fwd_data_b_o,
    output logic       wb_valid_o,
    output reg_addr_t  wb_dest_o,
    output data_word_t wb_result_o,
    output logic       flush_o,
    output data_word_t exception_pc_o
);

    // Slot state
    logic [`ROB_DEPTH-1:0] alloc_q;
    logic [`ROB_DEPTH-1:0] done_q;
    logic [`ROB_DEPTH-1:0] exc_q;
    reg_addr_t  dest_q   [`ROB_DEPTH];
    data_word_t pc_q     [`ROB_DEPTH];
    data_word_t result_q [`ROB_DEPTH];

    rob_tag_t head_q;
    rob_tag_t tail_q;
    logic     head_ready;

    // Tags are handed out in program order at the tail
    assign alloc_tag_o = tail_q;
    // The tail slot is still occupied only when every slot is taken
    assign full_o      = alloc_q[tail_q];
    assign empty_o     = ~|alloc_q;

    // ======================================================================
    // Head retirement and exception flush
    // ======================================================================

    assign head_ready     = alloc_q[head_q] && done_q[head_q];
    assign wb_valid_o     = head_ready && !exc_q[head_q];
    assign flush_o        = head_ready && exc_q[head_q];
    assign wb_dest_o      = dest_q[head_q];
    assign wb_result_o    = result_q[head_q];
    assign exception_pc_o = pc_q[head_q];

    // A flush drops every slot, including results arriving in the same cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_o) begin
            alloc_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (alloc_i) begin
                alloc_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            if (exe_write_i) begin
                done_q[exe_tag_i] <= 1'b1;
            end
            if (mul_write_i) begin
                done_q[mul_tag_i] <= 1'b1;
            end
            if (wb_valid_o) begin
                alloc_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
        end
    end

    // Both completion ports may write in the same cycle to different slots
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            dest_q[tail_q] <= alloc_dest_i;
            pc_q[tail_q]   <= alloc_pc_i;
        end
        if (exe_write_i) begin
            result_q[exe_tag_i] <= exe_result_i;
            exc_q[exe_tag_i]    <= exe_exception_i;
        end
        if (mul_write_i) begin
            result_q[mul_tag_i] <= mul_result_i;
            exc_q[mul_tag_i]    <= 1'b0;
        end
    end

    // ======================================================================
    // Forwarding search
    // ======================================================================

    // Walk from the head towards the tail so the youngest match wins
    always_comb begin
        rob_tag_t idx;
        fwd_hit_a_o  = 1'b0;
        fwd_data_a_o = '0;
        fwd_hit_b_o  = 1'b0;
        fwd_data_b_o = '0;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            idx = head_q + rob_tag_t'(i);
            if (alloc_q[idx] && done_q[idx] && (dest_q[idx] == fwd_src_a_i)) begin
                fwd_hit_a_o  = 1'b1;
                fwd_data_a_o = result_q[idx];
            end
            if (alloc_q[idx] && done_q[idx] && (dest_q[idx] == fwd_src_b_i)) begin
                fwd_hit_b_o  = 1'b1;
                fwd_data_b_o = result_q[idx];
            end
        end
    end

endmodule : reorder_buffer

// File: hw/back_end.sv
`timescale 1ns/100ps

`include "back_end_consts.svh"

module back_end import back_end_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       issue_valid_i,
    input  op_t        issue_op_i,
    input  reg_addr_t  issue_src_a_i,
    input  reg_addr_t  issue_src_b_i,
    input  reg_addr_t  issue_dest_i,
    input  data_word_t issue_operand_a_i,
    input  data_word_t issue_operand_b_i,
    input  logic       issue_imm_i,
    input  logic       issue_illegal_i,
    input  data_word_t issue_pc_i,
    output logic       issue_ready_o,
    output logic       wb_valid_o,
    output reg_addr_t  wb_dest_o,
    output data_word_t wb_result_o,
    output logic       flush_o,
    output data_word_t exception_pc_o,
    output logic       pipeline_empty_o
);

    // Forwarding
    data_word_t operand_a, operand_b;
    logic       rob_hit_a, rob_hit_b;
    data_word_t rob_data_a, rob_data_b;

    // Issue register contents
    logic       accept, ex_valid, ex_illegal;
    op_t        ex_op;
    reg_addr_t  ex_dest;
    rob_tag_t   ex_tag, alloc_tag;
    data_word_t ex_a, ex_b;

    // Unit results and status
    data_word_t alu_result, mul_result;
    logic       alu_write, alu_fwd_valid, mul_start;
    logic       mul_busy, mul_done, rob_full;
    reg_addr_t  mul_dest;
    rob_tag_t   mul_tag;

    // ======================================================================
    // Routing of the issue register to the units
    // ======================================================================

    // Illegal instructions complete through the ALU port with the exception flag
    assign alu_write     = ex_valid && ((ex_op != `OP_MUL) || ex_illegal);
    assign alu_fwd_valid = ex_valid && (ex_op != `OP_MUL) && !ex_illegal;
    assign mul_start     = ex_valid && (ex_op == `OP_MUL) && !ex_illegal;

    bypass_network u_bypass (
        .src_a_i      ( issue_src_a_i     ),
        .src_b_i      ( issue_src_b_i     ),
        .imm_i        ( issue_imm_i       ),
        .rf_a_i       ( issue_operand_a_i ),
        .rf_b_i       ( issue_operand_b_i ),
        .exe_valid_i  ( alu_fwd_valid     ),
        .exe_dest_i   ( ex_dest           ),
        .exe_result_i ( alu_result        ),
        .rob_hit_a_i  ( rob_hit_a         ),
        .rob_hit_b_i  ( rob_hit_b         ),
        .rob_data_a_i ( rob_data_a        ),
        .rob_data_b_i ( rob_data_b        ),
        .operand_a_o  ( operand_a         ),
        .operand_b_o  ( operand_b         )
    );

    // The PC is kept by the reorder buffer from allocation on
    issue_stage u_issue (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .issue_valid_i   ( issue_valid_i   ),
        .issue_op_i      ( issue_op_i      ),
        .issue_src_a_i   ( issue_src_a_i   ),
        .issue_src_b_i   ( issue_src_b_i   ),
        .issue_dest_i    ( issue_dest_i    ),
        .issue_imm_i     ( issue_imm_i     ),
        .issue_illegal_i ( issue_illegal_i ),
        .issue_pc_i      ( issue_pc_i      ),
        .operand_a_i     ( operand_a       ),
        .operand_b_i     ( operand_b       ),
        .rob_full_i      ( rob_full        ),
        .flush_i         ( flush_o         ),
        .mul_busy_i      ( mul_busy        ),
        .mul_dest_i      ( mul_dest        ),
        .issue_ready_o   ( issue_ready_o   ),
        .accept_o        ( accept          ),
        .ex_valid_o      ( ex_valid        ),
        .ex_op_o         ( ex_op           ),
        .ex_dest_o       ( ex_dest         ),
        .ex_tag_o        ( ex_tag          ),
        .ex_illegal_o    ( ex_illegal      ),
        .ex_pc_o         (                 ),
        .ex_a_o          ( ex_a            ),
        .ex_b_o          ( ex_b            ),
        .alloc_tag_i     ( alloc_tag       )
    );

    alu_unit u_alu (
        .op_i     ( ex_op      ),
        .a_i      ( ex_a       ),
        .b_i      ( ex_b       ),
        .result_o ( alu_result )
    );

    mul_unit u_mul (
        .clk_i    ( clk_i      ),
        .rst_n_i  ( rst_n_i    ),
        .flush_i  ( flush_o    ),
        .start_i  ( mul_start  ),
        .a_i      ( ex_a       ),
        .b_i      ( ex_b       ),
        .dest_i   ( ex_dest    ),
        .tag_i    ( ex_tag     ),
        .busy_o   ( mul_busy   ),
        .dest_o   ( mul_dest   ),
        .done_o   ( mul_done   ),
        .tag_o    ( mul_tag    ),
        .result_o ( mul_result )
    );

    // ======================================================================
    // Reorder buffer with writeback and exception handling at its head
    // ======================================================================

    reorder_buffer u_rob (
        .clk_i           ( clk_i            ),
        .rst_n_i         ( rst_n_i          ),
        .alloc_i         ( accept           ),
        .alloc_dest_i    ( issue_dest_i     ),
        .alloc_pc_i      ( issue_pc_i       ),
        .exe_write_i     ( alu_write        ),
        .exe_tag_i       ( ex_tag           ),
        .exe_result_i    ( alu_result       ),
        .exe_exception_i ( ex_illegal       ),
        .mul_write_i     ( mul_done         ),
        .mul_tag_i       ( mul_tag          ),
        .mul_result_i    ( mul_result       ),
        .fwd_src_a_i     ( issue_src_a_i    ),
        .fwd_src_b_i     ( issue_src_b_i    ),
        .alloc_tag_o     ( alloc_tag        ),
        .full_o          ( rob_full         ),
        .empty_o         ( pipeline_empty_o ),
        .fwd_hit_a_o     ( rob_hit_a        ),
        .fwd_data_a_o    ( rob_data_a       ),
        .fwd_hit_b_o     ( rob_hit_b        ),
        .fwd_data_b_o    ( rob_data_b       ),
        .wb_valid_o      ( wb_valid_o       ),
        .wb_dest_o       ( wb_dest_o        ),
        .wb_result_o     ( wb_result_o      ),
        .flush_o         ( flush_o          ),
        .exception_pc_o  ( exception_pc_o   )
    );

endmodule : back_end

// File: tb/back_end_props.sv
`timescale 1ns/100ps

module back_end_props (
    input logic clk_i,
    input logic rst_n_i,
    input logic issue_ready_i,
    input logic wb_valid_i,
    input logic flush_i
);

    // ======================================================================
    // Head of the reorder buffer
    // ======================================================================

    // The head either retires or flushes, never both in one cycle
    wb_flush_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(wb_valid_i && flush_i)
    ) else $error("Writeback and flush are high in the same cycle");

    // A flush must block the issue of any new instruction
    flush_blocks_issue: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) flush_i |-> !issue_ready_i
    ) else $error("Issue is ready while a flush is in progress");

    // Reset leaves the buffer empty so nothing retires right away
    quiet_after_reset: assert property (
        @(posedge clk_i) $rose(rst_n_i) |-> !wb_valid_i
    ) else $error("Writeback is high in the first cycle after reset");

endmodule : back_end_props

// File: tb/back_end_tb.sv
`timescale 1ns/100ps

`include "back_end_consts.svh"

module back_end_tb import back_end_pkg::*; ();

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * (`MUL_STEPS + 10);

    // One accepted instruction as the model expects to see it retire
    typedef struct packed {
        logic       illegal;
        reg_addr_t  dest;
        data_word_t result;
        data_word_t pc;
    } expected_entry_t;

    logic       clk_i;
    logic       rst_n_i;
    logic       issue_valid_i;
    op_t        issue_op_i;
    reg_addr_t  issue_src_a_i;
    reg_addr_t  issue_src_b_i;
    reg_addr_t  issue_dest_i;
    data_word_t issue_operand_a_i;
    data_word_t issue_operand_b_i;
    logic       issue_imm_i;
    logic       issue_illegal_i;
    data_word_t issue_pc_i;
    logic       issue_ready_o;
    logic       wb_valid_o;
    reg_addr_t  wb_dest_o;
    data_word_t wb_result_o;
    logic       flush_o;
    data_word_t exception_pc_o;
    logic       pipeline_empty_o;

    // Retired state feeds the DUT, speculative state follows program order
    integer          seed;
    data_word_t      retired_rf [32];
    data_word_t      spec_rf    [32];
    expected_entry_t expected_q [$];
    data_word_t      imm_value;
    data_word_t      next_pc;
    reg_addr_t       last_dest;
    reg_addr_t       busy_mul_dest;
    logic            pending;
    int issued          = 0;
    int retired         = 0;
    int dropped         = 0;
    int flushes         = 0;
    int stall_cycles    = 0;
    int cycle_count     = 0;
    int check_count     = 0;
    int error_count     = 0;
    int mul_cycles_left = 0;

    back_end UUT (.*);

    bind back_end back_end_props u_props (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .issue_ready_i ( issue_ready_o ),
        .wb_valid_i    ( wb_valid_o    ),
        .flush_i       ( flush_o       )
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ======================================================================
    // Reference model and checks
    // ======================================================================

    // Result rules per operation, the product keeps its low word only
    function automatic data_word_t model_result(input op_t op, input data_word_t a,
                                                input data_word_t b);
        logic [63:0] product;
        product = {32'd0, a} * {32'd0, b};
        case (op)
            `OP_ADD: return a + b;
            `OP_SUB: return a + ~b + 32'd1;
            `OP_AND: return a & b;
            `OP_OR:  return a | b;
            `OP_XOR: return a ^ b;
            `OP_SLL: return a << b[4:0];
            `OP_SRL: return a >> b[4:0];
            // Different signs decide on the sign of a, equal signs compare unsigned
            `OP_SLT: return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            `OP_MUL: return product[31:0];
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic finish_run;
        $display({"Checks: %0d, errors: %0d, issued: %0d, retired: %0d, ",
                  "flushes: %0d, dropped: %0d, stalls: %0d"},
                 check_count, error_count, issued, retired, flushes, dropped, stall_cycles);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    // About half the sources reuse the last destination to force back-to-back forwarding
    task automatic new_instruction;
        int pick;
        pick            = $unsigned($random(seed)) % 32;
        issue_op_i      = (pick < 5) ? `OP_MUL : op_t'(pick % 8);
        issue_dest_i    = reg_addr_t'($random(seed));
        issue_src_a_i   = ($random(seed) & 1) ? last_dest : reg_addr_t'($random(seed));
        issue_src_b_i   = (($random(seed) & 3) == 0) ? last_dest : reg_addr_t'($random(seed));
        issue_imm_i     = ($unsigned($random(seed)) % 4) == 0;
        issue_illegal_i = ($unsigned($random(seed)) % 40) == 0;
        imm_value       = $random(seed);
        issue_pc_i      = next_pc;
        next_pc         = next_pc + 32'd4;
        last_dest       = issue_dest_i;
    endtask

    // The instruction is held until accepted, its operands track the retired registers
    task automatic drive_inputs;
        if (!pending && (issued < NUM_INSTR) && (($unsigned($random(seed)) % 8) != 0)) begin
            new_instruction();
            pending = 1'b1;
        end
        issue_valid_i     = pending;
        issue_operand_a_i = retired_rf[issue_src_a_i];
        issue_operand_b_i = issue_imm_i ? imm_value : retired_rf[issue_src_b_i];
    endtask

    // Sampled at the falling edge, these are the events of the coming rising edge
    task automatic observe_outputs;
        expected_entry_t head;
        expected_entry_t entry;
        data_word_t      operand_b;
        logic            reads_mul_dest;
        logic            expected_ready;
        // A legal multiply blocks other multiplies and its readers until it completes
        // The queue holds exactly the instructions that own a buffer slot
        reads_mul_dest = (issue_src_a_i == busy_mul_dest)
                      || (!issue_imm_i && (issue_src_b_i == busy_mul_dest));
        expected_ready = !flush_o && (expected_q.size() < `ROB_DEPTH)
                      && !((mul_cycles_left > 0) && ((issue_op_i == `OP_MUL) || reads_mul_dest));
        check_value("issue ready", 32'(issue_ready_o), 32'(expected_ready));
        if (mul_cycles_left > 0) begin
            mul_cycles_left--;
        end
        if (flush_o) begin
            if (expected_q.size() == 0) begin
                error_count++;
                $display("Flush at %0t with no instruction outstanding", $time);
            end else begin
                head = expected_q.pop_front();
                check_value("flushing instruction is illegal", 32'(head.illegal), 32'd1);
                check_value("exception pc", exception_pc_o, head.pc);
                // The exception itself and every younger instruction are gone
                dropped = dropped + 1 + expected_q.size();
                expected_q.delete();
                spec_rf = retired_rf;
                mul_cycles_left = 0;
                flushes++;
            end
        end else if (wb_valid_o) begin
            if (expected_q.size() == 0) begin
                error_count++;
                $display("Writeback at %0t with no instruction outstanding", $time);
            end else begin
                head = expected_q.pop_front();
                check_value("writeback of an illegal instruction", 32'(head.illegal), 32'd0);
                check_value("writeback destination", 32'(wb_dest_o), 32'(head.dest));
                check_value("writeback result", wb_result_o, head.result);
                retired_rf[head.dest] = head.result;
                retired++;
            end
        end
        if (issue_valid_i && issue_ready_o) begin
            operand_b     = issue_imm_i ? imm_value : spec_rf[issue_src_b_i];
            entry.illegal = issue_illegal_i;
            entry.dest    = issue_dest_i;
            entry.pc      = issue_pc_i;
            entry.result  = model_result(issue_op_i, spec_rf[issue_src_a_i], operand_b);
            expected_q.push_back(entry);
            if (!issue_illegal_i) begin
                spec_rf[issue_dest_i] = entry.result;
                // Issue register cycle plus the iterations of the multiplier
                if (issue_op_i == `OP_MUL) begin
                    mul_cycles_left = `MUL_STEPS + 1;
                    busy_mul_dest   = issue_dest_i;
                end
            end
            issued++;
            pending = 1'b0;
        end else if (issue_valid_i) begin
            stall_cycles++;
        end
    endtask

    // ======================================================================
    // Stimulus and run control
    // ======================================================================

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the instruction stream did not drain",
                     cycle_count);
            error_count++;
            finish_run();
        end
    end

    initial begin
        seed              = 52;
        rst_n_i           = 1'b0;
        issue_valid_i     = 1'b0;
        issue_op_i        = '0;
        issue_src_a_i     = '0;
        issue_src_b_i     = '0;
        issue_dest_i      = '0;
        issue_operand_a_i = '0;
        issue_operand_b_i = '0;
        issue_imm_i       = 1'b0;
        issue_illegal_i   = 1'b0;
        issue_pc_i        = '0;
        imm_value         = '0;
        next_pc           = 32'h0000_1000;
        last_dest         = '0;
        busy_mul_dest     = '0;
        pending           = 1'b0;
        for (int i = 0; i < 32; i++) begin
            retired_rf[i] = $random(seed);
            spec_rf[i]    = retired_rf[i];
        end
        repeat (10) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        while ((issued < NUM_INSTR) || (expected_q.size() != 0)) begin
            drive_inputs();
            @(negedge clk_i);
            observe_outputs();
            @(posedge clk_i);
            #2;
        end
        issue_valid_i = 1'b0;
        // Once the model has drained, no slot may still be held in the DUT
        check_value("pipeline empty after drain", 32'(pipeline_empty_o), 32'd1);
        finish_run();
    end

endmodule : back_end_tb

// File: back_end.f
+incdir+hw
hw/back_end_pkg.sv
hw/bypass_network.sv
hw/issue_stage.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/reorder_buffer.sv
hw/back_end.sv
tb/back_end_props.sv
tb/back_end_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the back end testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module back_end_tb \
    -f back_end.f -o back_end_sim \
    && ./obj_dir/back_end_sim | tee sim.log \
    || { echo "Build or simulation failed"; exit 1; }

grep -q "ALL TESTS PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
